//--- diram_geom_pkg.sv
// Fixed geometry of 4 banks by 64 rows by 16 lines of 32 bits, and the line LSB selects the channel
`default_nettype none

package diram_geom_pkg;

    // --------------------
    // Geometry
    localparam int DATA_WIDTH  = 32;
    localparam int NUM_BANKS   = 4;
    localparam int BANK_WIDTH  = 2;
    localparam int NUM_ROWS    = 64;
    localparam int ROW_WIDTH   = 6;
    localparam int CL_PER_PAGE = 16;
    localparam int LINE_WIDTH  = 4;

    // One channel holds half of every page
    localparam int CHAN_ADDR_WIDTH = BANK_WIDTH + ROW_WIDTH + LINE_WIDTH - 1;
    localparam int CHAN_DEPTH      = NUM_BANKS * NUM_ROWS * CL_PER_PAGE / 2;

    // --------------------
    // Types
    typedef logic [DATA_WIDTH-1:0]      mem_data_t;
    typedef logic [CHAN_ADDR_WIDTH-1:0] chan_addr_t;

    // Line LSB 0 is even, 1 is odd
    typedef struct packed {
        logic [BANK_WIDTH-1:0] bank;
        logic [ROW_WIDTH-1:0]  row;
        logic [LINE_WIDTH-1:0] line;
    } mem_addr_t;

    // Backdoor write into one channel
    typedef struct packed {
        logic       load;
        chan_addr_t addr;
        mem_data_t  data;
    } cfg_load_t;

    // Word address in a channel, channel bit dropped
    function automatic chan_addr_t to_chan_addr(
        input logic [BANK_WIDTH-1:0] bank,
        input logic [ROW_WIDTH-1:0]  row,
        input logic [LINE_WIDTH-1:0] line
    );
        return {bank, row, line[LINE_WIDTH-1:1]};
    endfunction

endpackage : diram_geom_pkg

`default_nettype wire

//--- dfi_cmd_pkg.sv
// Single-rate command bus only, and RD_LATENCY must be at least 2 for the model read pipeline
`default_nettype none

package dfi_cmd_pkg;

    import diram_geom_pkg::*;

    // --------------------
    // Encodings
    localparam int CMD_WIDTH = 2;

    // Address field is wide enough for a row
    localparam int DFI_ADDR_WIDTH = ROW_WIDTH;

    // Cycles from read command to data
    localparam int RD_LATENCY = 3;

    // Opcode as driven on cmd1, cmd0
    typedef enum logic [CMD_WIDTH-1:0] {
        CMD_PRECHARGE = 2'b00,
        CMD_ACTIVATE  = 2'b01,
        CMD_READ      = 2'b10,
        CMD_WRITE     = 2'b11
    } dfi_cmd_e;

    // --------------------
    // Command bus
    // Row on activate, line on read and write
    typedef struct packed {
        logic                      cs_n;
        dfi_cmd_e                  cmd;
        logic [BANK_WIDTH-1:0]     bank;
        logic [DFI_ADDR_WIDTH-1:0] addr;
        mem_data_t                 data;
    } dfi_bus_t;

    // --------------------
    // Request from the manager
    typedef struct packed {
        logic      wr;
        mem_addr_t addr;
        mem_data_t data;
    } mem_req_t;

endpackage : dfi_cmd_pkg

`default_nettype wire

//--- diram_channel.sv
// Behavioral storage with no reset, so contents are unknown until written or preloaded
`timescale 1ns/100ps
`default_nettype none

module diram_channel
    import diram_geom_pkg::*;
(
    input  logic       clk2x,
    input  logic       wr_en,
    input  logic       rd_en,
    input  chan_addr_t addr,
    input  mem_data_t  wdata,
    input  cfg_load_t  cfg,
    output mem_data_t  rdata
);

    // Half of every page lives here
    mem_data_t mem [CHAN_DEPTH];

    // --------------------
    // Writes
    // Backdoor first, so a normal write to the same line wins
    always_ff @(posedge clk2x)
    begin
        if (cfg.load)
        begin
            mem[cfg.addr] <= cfg.data;
        end
        if (wr_en)
        begin
            mem[addr] <= wdata;
        end
    end

    // --------------------
    // Registered read
    // Held between reads
    always_ff @(posedge clk2x)
    begin
        if (rd_en)
        begin
            rdata <= mem[addr];
        end
    end

endmodule : diram_channel

`default_nettype wire

//--- diram_port_model.sv
// Behavioral DiRAM port, no refresh or bank timing, and reads return RD_LATENCY cycles after command
`timescale 1ns/100ps
`default_nettype none

module diram_port_model
    import diram_geom_pkg::*;
    import dfi_cmd_pkg::*;
(
    input  logic      clk2x,
    input  logic      arst_n,
    input  dfi_bus_t  dfi,
    input  cfg_load_t cfg_even,
    input  cfg_load_t cfg_odd,
    output logic      rd_valid,
    output mem_data_t rd_data
);

    logic [NUM_BANKS-1:0]  bank_open;
    logic [ROW_WIDTH-1:0]  open_row [NUM_BANKS];
    logic                  is_rd;
    logic                  is_wr;
    logic                  chan_sel;
    chan_addr_t            chan_addr;
    mem_data_t             rdata_even;
    mem_data_t             rdata_odd;
    logic [RD_LATENCY-1:0] rd_vld_sr;
    logic                  rd_chan_q;
    mem_data_t             rd_data_sr [RD_LATENCY-1];

    // --------------------
    // Command decode
    assign is_rd     = !dfi.cs_n && (dfi.cmd == CMD_READ);
    assign is_wr     = !dfi.cs_n && (dfi.cmd == CMD_WRITE);
    // Line LSB picks the channel
    assign chan_sel  = dfi.addr[0];
    assign chan_addr = to_chan_addr(dfi.bank, open_row[dfi.bank], dfi.addr[LINE_WIDTH-1:0]);

    // Open-row state per bank
    always_ff @(posedge clk2x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bank_open <= '0;
        end
        else if (!dfi.cs_n)
        begin
            if (dfi.cmd == CMD_ACTIVATE)
                bank_open[dfi.bank] <= 1'b1;
            else if (dfi.cmd == CMD_PRECHARGE)
                bank_open[dfi.bank] <= 1'b0;
        end
    end

    always_ff @(posedge clk2x)
    begin
        if (!dfi.cs_n && (dfi.cmd == CMD_ACTIVATE))
        begin
            open_row[dfi.bank] <= dfi.addr;
        end
    end

    // --------------------
    // Channels
    diram_channel even_chan (
        .clk2x (clk2x),
        .wr_en (is_wr && !chan_sel),
        .rd_en (is_rd && !chan_sel),
        .addr  (chan_addr),
        .wdata (dfi.data),
        .cfg   (cfg_even),
        .rdata (rdata_even)
    );

    diram_channel odd_chan (
        .clk2x (clk2x),
        .wr_en (is_wr && chan_sel),
        .rd_en (is_rd && chan_sel),
        .addr  (chan_addr),
        .wdata (dfi.data),
        .cfg   (cfg_odd),
        .rdata (rdata_odd)
    );

    // --------------------
    // Read return pipeline
    // Valid runs the full depth, channel choice only up to the channel output
    always_ff @(posedge clk2x or negedge arst_n)
    begin
        if (!arst_n)
            rd_vld_sr <= '0;
        else
            rd_vld_sr <= {rd_vld_sr[RD_LATENCY-2:0], is_rd};
    end

    // Data follows one cycle behind the channel register
    always_ff @(posedge clk2x)
    begin
        rd_chan_q     <= chan_sel;
        rd_data_sr[0] <= rd_chan_q ? rdata_odd : rdata_even;
        for (int i = 1; i < RD_LATENCY - 1; i++)
        begin
            rd_data_sr[i] <= rd_data_sr[i-1];
        end
    end

    assign rd_valid = rd_vld_sr[RD_LATENCY-1];
    assign rd_data  = rd_data_sr[RD_LATENCY-2];

    // --------------------
    // Checks
    // Controller must have activated the bank
    a_access_bank_open: assert property (
        @(posedge clk2x) disable iff (!arst_n) (is_rd || is_wr) |-> bank_open[dfi.bank]
    );

    // No activate over an open row
    a_act_bank_closed: assert property (
        @(posedge clk2x) disable iff (!arst_n)
        (!dfi.cs_n && (dfi.cmd == CMD_ACTIVATE)) |-> !bank_open[dfi.bank]
    );

endmodule : diram_port_model

`default_nettype wire

//--- mgr_mem_req_cntl.sv
// One request in flight, rows left open after access, and req_valid must stay low while busy is high
`timescale 1ns/100ps
`default_nettype none

module mgr_mem_req_cntl
    import diram_geom_pkg::*;
    import dfi_cmd_pkg::*;
(
    input  logic     clk2x,
    input  logic     arst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     busy,
    output dfi_bus_t dfi
);

    // State names the command on the bus this cycle
    typedef enum logic [1:0] {
        IDLE,
        PRECHARGE,
        ACTIVATE,
        ACCESS
    } state_e;

    state_e                state;
    mem_req_t              pend;
    logic [NUM_BANKS-1:0]  bank_open;
    logic [ROW_WIDTH-1:0]  open_row [NUM_BANKS];
    logic                  accept;
    logic                  req_hit;

    // --------------------
    // Hit or miss
    // New request only between commands sequences
    assign busy    = (state == PRECHARGE) || (state == ACTIVATE);
    assign accept  = req_valid && !busy;
    assign req_hit = bank_open[req.addr.bank] && (open_row[req.addr.bank] == req.addr.row);

    // --------------------
    // Sequencer
    always_ff @(posedge clk2x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            bank_open <= '0;
        end
        else
        begin
            case (state)
                PRECHARGE:
                    state <= ACTIVATE;
                ACTIVATE:
                    state <= ACCESS;
                default:
                begin
                    // IDLE and ACCESS both take a new request
                    if (accept)
                    begin
                        if (req_hit)
                            state <= ACCESS;
                        else if (bank_open[req.addr.bank])
                            state <= PRECHARGE;
                        else
                            state <= ACTIVATE;
                        // Open by the time the next request arrives
                        bank_open[req.addr.bank] <= 1'b1;
                    end
                    else
                    begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Pending request and row table contents
    always_ff @(posedge clk2x)
    begin
        if (accept)
        begin
            pend                    <= req;
            open_row[req.addr.bank] <= req.addr.row;
        end
    end

    // --------------------
    // Command bus
    always_comb
    begin
        dfi.cs_n = 1'b1;
        dfi.cmd  = CMD_PRECHARGE;
        dfi.bank = pend.addr.bank;
        dfi.addr = pend.addr.row;
        dfi.data = pend.data;
        case (state)
            PRECHARGE:
                dfi.cs_n = 1'b0;
            ACTIVATE:
            begin
                dfi.cs_n = 1'b0;
                dfi.cmd  = CMD_ACTIVATE;
            end
            ACCESS:
            begin
                dfi.cs_n = 1'b0;
                dfi.cmd  = pend.wr ? CMD_WRITE : CMD_READ;
                // Line sits in the low address bits
                dfi.addr = {{(DFI_ADDR_WIDTH-LINE_WIDTH){1'b0}}, pend.addr.line};
            end
            default:
                ;
        endcase
    end

    // --------------------
    // Checks
    // Requester honours busy
    a_no_strobe_busy: assert property (
        @(posedge clk2x) disable iff (!arst_n) req_valid |-> !busy
    );

    // Quiet bus one cycle after a free cycle with no strobe
    a_idle_cs_high: assert property (
        @(posedge clk2x) disable iff (!arst_n) (!busy && !req_valid) |=> dfi.cs_n
    );

endmodule : mgr_mem_req_cntl

`default_nettype wire

//--- mgr_dram_port.sv
// Single manager port, and preload through cfg_even and cfg_odd only while no command targets that line
`timescale 1ns/100ps
`default_nettype none

module mgr_dram_port
    import diram_geom_pkg::*;
    import dfi_cmd_pkg::*;
(
    input  logic      clk2x,
    input  logic      arst_n,
    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      busy,
    input  cfg_load_t cfg_even,
    input  cfg_load_t cfg_odd,
    output logic      rd_valid,
    output mem_data_t rd_data
);

    // Command bus between controller and port
    dfi_bus_t dfi;

    // --------------------
    // Request controller
    mgr_mem_req_cntl req_cntl (
        .clk2x     (clk2x),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .dfi       (dfi)
    );

    // --------------------
    // DRAM port
    diram_port_model port_model (
        .clk2x    (clk2x),
        .arst_n   (arst_n),
        .dfi      (dfi),
        .cfg_even (cfg_even),
        .cfg_odd  (cfg_odd),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule : mgr_dram_port

`default_nettype wire

//--- mgr_dram_port_checker.sv
// Reads of lines never written or preloaded are not modeled, and latency is checked on page hits only
`timescale 1ns/100ps
`default_nettype none

module mgr_dram_port_checker
    import diram_geom_pkg::*;
    import dfi_cmd_pkg::*;
(
    input  logic      clk2x,
    input  logic      arst_n,
    input  int        test_id,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      busy,
    input  cfg_load_t cfg_even,
    input  cfg_load_t cfg_odd,
    input  logic      rd_valid,
    input  mem_data_t rd_data,
    output int        error_count,
    output int        read_count,
    output int        pending
);

    // Access command one cycle after acceptance, then the read latency
    localparam int HIT_LATENCY = RD_LATENCY + 1;

    // Due cycle is -1 for a miss
    typedef struct packed {
        mem_data_t data;
        int        due;
    } exp_read_t;

    mem_data_t            mirror [NUM_BANKS*NUM_ROWS*CL_PER_PAGE];
    logic [NUM_BANKS-1:0] row_valid;
    logic [ROW_WIDTH-1:0] row_open [NUM_BANKS];
    exp_read_t            exp_q [$];
    exp_read_t            exp;
    int                   cycle;
    int                   busy_left;

    function automatic string test_label(input int id);
        case (id)
            1:       return "reset";
            2:       return "preload";
            3:       return "write_read";
            4:       return "page_hit";
            5:       return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    // Reference read from the mirror
    function automatic mem_data_t expected_read(input mem_addr_t addr);
        return mirror[addr];
    endfunction

    always @(posedge clk2x)
    begin
        if (!arst_n)
        begin
            cycle       = 0;
            busy_left   = 0;
            row_valid   = '0;
            error_count = 0;
            read_count  = 0;
            exp_q.delete();
        end
        else
        begin
            cycle++;
            // Backdoor address lacks the line LSB, which is the channel
            if (cfg_even.load)
                mirror[{cfg_even.addr, 1'b0}] = cfg_even.data;
            if (cfg_odd.load)
                mirror[{cfg_odd.addr, 1'b1}] = cfg_odd.data;

            // --------------------
            // Busy covers the precharge and activate cycles
            if (busy !== (busy_left > 0))
            begin
                error_count++;
                $display("mismatch test=%s busy expected=%0b actual=%0b",
                    test_label(test_id), busy_left > 0, busy);
            end
            if (busy_left > 0)
                busy_left--;

            // --------------------
            // Returned reads, oldest first
            if (rd_valid && exp_q.size() == 0)
            begin
                error_count++;
                $display("test %s: rd_valid at cycle %0d with no read pending",
                    test_label(test_id), cycle);
            end
            else if (rd_valid)
            begin
                exp = exp_q.pop_front();
                read_count++;
                if (rd_data !== exp.data)
                begin
                    error_count++;
                    $display("mismatch test=%s expected=%h actual=%h",
                        test_label(test_id), exp.data, rd_data);
                end
                if (exp.due >= 0 && exp.due != cycle)
                begin
                    error_count++;
                    $display("mismatch test=%s rd_valid cycle expected=%0d actual=%0d",
                        test_label(test_id), exp.due, cycle);
                end
            end

            // --------------------
            // Accepted requests
            if (req_valid && busy)
            begin
                error_count++;
                $display("test %s: request strobed while busy at cycle %0d",
                    test_label(test_id), cycle);
            end
            else if (req_valid)
            begin
                // Closed bank needs an activate, other row also a precharge
                if (!row_valid[req.addr.bank])
                    busy_left = 1;
                else if (row_open[req.addr.bank] != req.addr.row)
                    busy_left = 2;
                else
                    busy_left = 0;
                if (req.wr)
                begin
                    mirror[req.addr] = req.data;
                end
                else
                begin
                    exp.data = expected_read(req.addr);
                    // Hit when the bank already holds this row
                    exp.due  = (busy_left == 0) ? cycle + HIT_LATENCY : -1;
                    exp_q.push_back(exp);
                end
                // Rows stay open
                row_valid[req.addr.bank] = 1'b1;
                row_open[req.addr.bank]  = req.addr.row;
            end
        end
        pending = exp_q.size();
    end

endmodule : mgr_dram_port_checker

`default_nettype wire

//--- mgr_dram_port_tb.sv
// Fixed seed, one idle cycle between requests except hit bursts, and reads only of lines written
`timescale 1ns/100ps
`default_nettype none

module mgr_dram_port_tb
    import diram_geom_pkg::*;
    import dfi_cmd_pkg::*;
();

    localparam int NUM_PRELOAD    = 8;
    localparam int NUM_WR_RD      = 16;
    localparam int NUM_HITS       = 8;
    localparam int NUM_RANDOM     = 60;
    localparam int TOTAL_REQS     = NUM_PRELOAD + 2*NUM_WR_RD + 2*NUM_HITS + NUM_RANDOM;
    // Worst case per request is well under 8 cycles
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 8 + 200;

    logic      clk2x;
    logic      arst_n;
    logic      req_valid;
    mem_req_t  req;
    logic      busy;
    cfg_load_t cfg_even;
    cfg_load_t cfg_odd;
    logic      rd_valid;
    mem_data_t rd_data;
    int        test_id;
    int        error_count;
    int        read_count;
    int        pending;
    int        tb_errors;
    int        reads_issued;
    int        timeout_cnt;
    int        seed;
    bit        written [NUM_BANKS*NUM_ROWS*CL_PER_PAGE];

    mgr_dram_port mgr_dram_port_i (.*);

    mgr_dram_port_checker port_check (.*);

    // 4 ns period
    always #2 clk2x = ~clk2x;

    // --------------------
    // Helpers
    function automatic mem_addr_t make_addr(input int bank, input int row, input int line);
        mem_addr_t a;
        a.bank = bank[BANK_WIDTH-1:0];
        a.row  = row[ROW_WIDTH-1:0];
        a.line = line[LINE_WIDTH-1:0];
        return a;
    endfunction

    // Busy low in a cycle with no strobe means free in the next one
    task automatic wait_ready();
        @(negedge clk2x);
        while (busy)
            @(negedge clk2x);
    endtask

    task automatic send_req(input logic wr, input mem_addr_t addr, input mem_data_t data);
        mem_req_t r;
        r.wr   = wr;
        r.addr = addr;
        r.data = data;
        wait_ready();
        @(posedge clk2x);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk2x);
        req_valid <= 1'b0;
        if (wr)
            written[addr] = 1'b1;
        else
            reads_issued++;
    endtask

    // Reads on consecutive cycles, row must already be open
    task automatic send_hit_burst(input mem_addr_t base, input int count);
        mem_req_t r;
        r      = '0;
        r.addr = base;
        wait_ready();
        for (int i = 0; i < count; i++)
        begin
            r.addr.line = base.line + i[LINE_WIDTH-1:0];
            @(posedge clk2x);
            req_valid <= 1'b1;
            req       <= r;
            reads_issued++;
        end
        @(posedge clk2x);
        req_valid <= 1'b0;
    endtask

    // Channel word address drops the line LSB
    task automatic preload_line(input mem_addr_t addr, input mem_data_t data);
        cfg_load_t cfg;
        cfg.load = 1'b1;
        cfg.addr = {addr.bank, addr.row, addr.line[LINE_WIDTH-1:1]};
        cfg.data = data;
        @(posedge clk2x);
        if (addr.line[0])
            cfg_odd <= cfg;
        else
            cfg_even <= cfg;
        @(posedge clk2x);
        cfg_even <= '0;
        cfg_odd  <= '0;
        written[addr] = 1'b1;
    endtask

    task automatic drain_reads();
        @(negedge clk2x);
        while (pending != 0)
            @(negedge clk2x);
    endtask

    // --------------------
    // Timeout
    initial
    begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk2x);
            timeout_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // --------------------
    // Stimulus
    initial
    begin
        mem_addr_t addr;
        int        rnd;
        logic      do_wr;
        seed         = 38;
        clk2x        = 1'b0;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        cfg_even     = '0;
        cfg_odd      = '0;
        test_id      = 1;
        tb_errors    = 0;
        reads_issued = 0;

        // Reset for 2 cycles
        repeat (2) @(posedge clk2x);
        arst_n <= 1'b1;
        @(negedge clk2x);
        if (busy !== 1'b0)
        begin
            tb_errors++;
            $display("mismatch test=reset busy expected=0 actual=%b", busy);
        end
        if (rd_valid !== 1'b0)
        begin
            tb_errors++;
            $display("mismatch test=reset rd_valid expected=0 actual=%b", rd_valid);
        end

        // Preload both channels, then read back
        test_id = 2;
        for (int i = 0; i < NUM_PRELOAD; i++)
            preload_line(make_addr(i, 40 + i, i), 32'hc0de_0000 + i);
        for (int i = 0; i < NUM_PRELOAD; i++)
            send_req(1'b0, make_addr(i, 40 + i, i), '0);
        drain_reads();

        // All banks, both channels
        test_id = 3;
        for (int i = 0; i < NUM_WR_RD; i++)
        begin
            rnd = $random(seed);
            send_req(1'b1, make_addr(i, i * 5, i), rnd);
        end
        for (int i = 0; i < NUM_WR_RD; i++)
            send_req(1'b0, make_addr(i, i * 5, i), '0);
        drain_reads();

        // Writes open the row, reads follow back to back
        test_id = 4;
        for (int i = 0; i < NUM_HITS; i++)
            send_req(1'b1, make_addr(3, 20, i), 32'h5a5a_0000 + i);
        send_hit_burst(make_addr(3, 20, 0), NUM_HITS);
        drain_reads();

        // Few rows per bank, so conflicts force precharges
        test_id = 5;
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rnd   = $random(seed);
            addr  = make_addr(rnd[1:0], rnd[3:2], rnd[7:4]);
            do_wr = rnd[8] || !written[addr];
            rnd   = $random(seed);
            send_req(do_wr, addr, rnd);
        end
        drain_reads();

        if (read_count != reads_issued)
        begin
            tb_errors++;
            $display("only %0d of %0d reads returned", read_count, reads_issued);
        end
        $display("errors: %0d in checker, %0d in testbench, %0d reads checked",
            error_count, tb_errors, read_count);
        if (error_count + tb_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : mgr_dram_port_tb

`default_nettype wire

//--- mgr_dram_port.f
diram_geom_pkg.sv
dfi_cmd_pkg.sv
diram_channel.sv
diram_port_model.sv
mgr_mem_req_cntl.sv
mgr_dram_port.sv
mgr_dram_port_checker.sv
mgr_dram_port_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mgr_dram_port_tb
FILELIST  = mgr_dram_port.f
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "help   list the targets"
	@echo "test   build with Verilator and run the simulation"
	@echo "clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
